//--- files.f
rtl/mem_bus_pkg.sv
rtl/cache_cfg_pkg.sv
rtl/icache_req_format.sv
rtl/read_req_arbiter.sv
rtl/read_resp_router.sv
rtl/refill_upsizer.sv
rtl/cache_mem_bridge.sv
verification/cache_mem_bridge_assertions.sv
verification/tb_cache_mem_bridge.sv

//--- rtl/cache_cfg_pkg.sv
/*
 * Instruction cache line geometry and the transaction ID
 * split between the instruction and data caches
 */

`default_nettype none

package cache_cfg_pkg;
  import mem_bus_pkg::*;

  localparam int ICACHE_LINE_WIDTH     = 128;
  localparam int ICACHE_BEATS          = ICACHE_LINE_WIDTH / MEM_DATA_WIDTH;
  localparam int ICACHE_OFFSET_BITS    = $clog2(ICACHE_LINE_WIDTH / 8);
  localparam int ICACHE_BEAT_IDX_WIDTH = $clog2(ICACHE_BEATS);

  typedef logic [MEM_ADDR_WIDTH-ICACHE_OFFSET_BITS-1:0] icache_line_addr_t;
  typedef logic [ICACHE_LINE_WIDTH-1:0]                 icache_line_t;

  // Reserved for instruction refills, data cache uses 1 to 3
  localparam mem_id_t ICACHE_MEM_ID = mem_id_t'(0);

endpackage

`default_nettype wire

//--- rtl/cache_mem_bridge.sv
/*
 * Cache refill bridge top: instruction request build, read
 * arbitration, response routing and instruction line upsizing
 */

`timescale 1ns/1ps
`default_nettype none

module cache_mem_bridge
  import mem_bus_pkg::*;
  import cache_cfg_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  // Instruction cache
  input  wire logic              icache_req_valid_i,
  input  wire icache_line_addr_t icache_line_addr_i,
  output logic                   icache_resp_valid_o,
  output icache_line_t           icache_line_o,

  // Data cache
  input  wire logic              dcache_req_valid_i,
  input  wire mem_req_t          dcache_req_i,
  output logic                   dcache_resp_valid_o,
  output mem_resp_t              dcache_resp_o,

  // Memory read bus
  output logic                   mem_req_valid_o,
  output mem_req_t               mem_req_o,
  input  wire logic              mem_resp_valid_i,
  input  wire mem_resp_t         mem_resp_i
);

  logic      ireq_valid;
  mem_req_t  ireq;
  logic      ibeat_valid;
  mem_resp_t ibeat;

  icache_req_format i_icache_req_format (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .icache_req_valid_i (icache_req_valid_i),
    .icache_line_addr_i (icache_line_addr_i),
    .req_valid_o        (ireq_valid),
    .req_o              (ireq)
  );

  read_req_arbiter i_read_req_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .icache_valid_i (ireq_valid),
    .icache_req_i   (ireq),
    .dcache_valid_i (dcache_req_valid_i),
    .dcache_req_i   (dcache_req_i),
    .req_valid_o    (mem_req_valid_o),
    .req_o          (mem_req_o)
  );

  read_resp_router i_read_resp_router (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .resp_valid_i        (mem_resp_valid_i),
    .resp_i              (mem_resp_i),
    .icache_beat_valid_o (ibeat_valid),
    .icache_beat_o       (ibeat),
    .dcache_resp_valid_o (dcache_resp_valid_o),
    .dcache_resp_o       (dcache_resp_o)
  );

  refill_upsizer i_refill_upsizer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_valid_i (ibeat_valid),
    .beat_i       (ibeat),
    .line_valid_o (icache_resp_valid_o),
    .line_o       (icache_line_o)
  );

endmodule

`default_nettype wire

//--- rtl/icache_req_format.sv
/*
 * Instruction miss request stage: registers the line address
 * and builds a full line burst request with the reserved ID
 */

`timescale 1ns/1ps
`default_nettype none

module icache_req_format
  import mem_bus_pkg::*;
  import cache_cfg_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  input  wire logic              icache_req_valid_i,
  input  wire icache_line_addr_t icache_line_addr_i,

  output logic                   req_valid_o,
  output mem_req_t               req_o
);

  logic     req_valid_q;
  mem_req_t req_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= icache_req_valid_i;
    end
  end

  // Whole line burst, line aligned
  always_ff @(posedge clk_i) begin
    if (icache_req_valid_i) begin
      req_q.addr <= {icache_line_addr_i, {ICACHE_OFFSET_BITS{1'b0}}};
      req_q.len  <= mem_len_t'(ICACHE_BEATS - 1);
      req_q.id   <= ICACHE_MEM_ID;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

endmodule

`default_nettype wire

//--- rtl/mem_bus_pkg.sv
/*
 * Memory read bus definitions: field widths, vector types,
 * and the request and response structs used by every stage
 */

`default_nettype none

package mem_bus_pkg;

  localparam int MEM_DATA_WIDTH = 32;
  localparam int MEM_ADDR_WIDTH = 32;
  localparam int MEM_ID_WIDTH   = 2;
  // Holds the beat count minus one
  localparam int MEM_LEN_WIDTH  = 2;

  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [MEM_DATA_WIDTH-1:0] mem_data_t;
  typedef logic [MEM_ID_WIDTH-1:0]   mem_id_t;
  typedef logic [MEM_LEN_WIDTH-1:0]  mem_len_t;

  // Read request toward memory
  typedef struct packed {
    mem_addr_t addr;
    mem_len_t  len;
    mem_id_t   id;
  } mem_req_t;

  // One read beat from memory
  typedef struct packed {
    mem_data_t data;
    mem_id_t   id;
    logic      last;
  } mem_resp_t;

endpackage

`default_nettype wire

//--- rtl/read_req_arbiter.sv
/*
 * Fixed-priority read request arbiter, data cache first,
 * with a one-entry hold slot for a losing instruction request
 */

`timescale 1ns/1ps
`default_nettype none

module read_req_arbiter
  import mem_bus_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,

  input  wire logic     icache_valid_i,
  input  wire mem_req_t icache_req_i,
  input  wire logic     dcache_valid_i,
  input  wire mem_req_t dcache_req_i,

  output logic          req_valid_o,
  output mem_req_t      req_o
);

  logic     hold_valid_q, hold_valid_d;
  mem_req_t hold_req_q, hold_req_d;
  logic     grant_valid;
  mem_req_t grant_req;
  logic     req_valid_q;
  mem_req_t req_q;

  // Priority: data request, then parked request, then new instruction request
  always_comb begin
    grant_valid  = 1'b0;
    grant_req    = dcache_req_i;
    hold_valid_d = hold_valid_q;
    hold_req_d   = hold_req_q;
    if (dcache_valid_i) begin
      grant_valid = 1'b1;
      if (icache_valid_i) begin
        hold_valid_d = 1'b1;
        hold_req_d   = icache_req_i;
      end
    end else if (hold_valid_q) begin
      grant_valid  = 1'b1;
      grant_req    = hold_req_q;
      hold_valid_d = icache_valid_i;
      hold_req_d   = icache_req_i;
    end else if (icache_valid_i) begin
      grant_valid = 1'b1;
      grant_req   = icache_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
      req_valid_q  <= 1'b0;
    end else begin
      hold_valid_q <= hold_valid_d;
      req_valid_q  <= grant_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_req_q <= hold_req_d;
    if (grant_valid) begin
      req_q <= grant_req;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

endmodule

`default_nettype wire

//--- rtl/read_resp_router.sv
/*
 * Read response router: registers each memory beat onto the
 * instruction refill path or the data cache path by its ID
 */

`timescale 1ns/1ps
`default_nettype none

module read_resp_router
  import mem_bus_pkg::*;
  import cache_cfg_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,

  input  wire logic      resp_valid_i,
  input  wire mem_resp_t resp_i,

  output logic           icache_beat_valid_o,
  output mem_resp_t      icache_beat_o,
  output logic           dcache_resp_valid_o,
  output mem_resp_t      dcache_resp_o
);

  logic      is_icache;
  logic      icache_valid_q;
  logic      dcache_valid_q;
  mem_resp_t beat_q;

  assign is_icache = (resp_i.id == ICACHE_MEM_ID);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      icache_valid_q <= 1'b0;
      dcache_valid_q <= 1'b0;
    end else begin
      icache_valid_q <= resp_valid_i & is_icache;
      dcache_valid_q <= resp_valid_i & ~is_icache;
    end
  end

  // One payload register, the strobes select the owner
  always_ff @(posedge clk_i) begin
    if (resp_valid_i) begin
      beat_q <= resp_i;
    end
  end

  assign icache_beat_valid_o = icache_valid_q;
  assign icache_beat_o       = beat_q;
  assign dcache_resp_valid_o = dcache_valid_q;
  assign dcache_resp_o       = beat_q;

endmodule

`default_nettype wire

//--- rtl/refill_upsizer.sv
/*
 * Instruction refill upsizer: collects narrow beats into
 * a full cache line and strobes it after the last beat
 */

`timescale 1ns/1ps
`default_nettype none

module refill_upsizer
  import mem_bus_pkg::*;
  import cache_cfg_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,

  input  wire logic      beat_valid_i,
  input  wire mem_resp_t beat_i,

  output logic           line_valid_o,
  output icache_line_t   line_o
);

  logic [ICACHE_BEAT_IDX_WIDTH-1:0] beat_idx_q;
  logic                             line_valid_q;
  icache_line_t                     line_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      beat_idx_q   <= '0;
      line_valid_q <= 1'b0;
    end else begin
      line_valid_q <= beat_valid_i & beat_i.last;
      if (beat_valid_i) begin
        // Restart at slot 0 for the next burst
        if (beat_i.last) begin
          beat_idx_q <= '0;
        end else begin
          beat_idx_q <= beat_idx_q + 1'b1;
        end
      end
    end
  end

  // First beat lands in the low word
  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      line_q[beat_idx_q*MEM_DATA_WIDTH +: MEM_DATA_WIDTH] <= beat_i.data;
    end
  end

  assign line_valid_o = line_valid_q;
  assign line_o       = line_q;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the cache refill bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_cache_mem_bridge -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

//--- verification/cache_mem_bridge_assertions.sv
/*
 * Concurrent checks bound to the bridge top: strobes after reset,
 * instruction burst length, single-cycle line strobe
 */

`timescale 1ns/1ps
`default_nettype none

module cache_mem_bridge_assertions
  import mem_bus_pkg::*;
  import cache_cfg_pkg::*;
(
  input wire logic     clk_i,
  input wire logic     rst_ni,
  input wire logic     mem_req_valid_i,
  input wire mem_req_t mem_req_i,
  input wire logic     icache_resp_valid_i,
  input wire logic     dcache_resp_valid_i
);

  // All strobes idle in the first cycle out of reset
  assert property (@(posedge clk_i) $rose(rst_ni) |->
      (!mem_req_valid_i && !icache_resp_valid_i && !dcache_resp_valid_i))
    else $error("strobe high in the cycle after reset release");

  // Instruction refills always ask for a whole line
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mem_req_valid_i && mem_req_i.id == ICACHE_MEM_ID) |->
      (mem_req_i.len == mem_len_t'(ICACHE_BEATS - 1)))
    else $error("instruction request with wrong burst length");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      icache_resp_valid_i |=> !icache_resp_valid_i)
    else $error("instruction line strobe high in two consecutive cycles");

endmodule

bind cache_mem_bridge cache_mem_bridge_assertions i_cache_mem_bridge_assertions (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .mem_req_valid_i     (mem_req_valid_o),
  .mem_req_i           (mem_req_o),
  .icache_resp_valid_i (icache_resp_valid_o),
  .dcache_resp_valid_i (dcache_resp_valid_o)
);

`default_nettype wire

//--- verification/tb_cache_mem_bridge.sv
/*
 * Testbench for the cache refill bridge: clock, reset, stimulus
 * table, memory model that answers bursts in order, and checks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cache_mem_bridge
  import mem_bus_pkg::*;
  import cache_cfg_pkg::*;
;

  typedef enum logic [1:0] {ROW_INSTR, ROW_DATA, ROW_COLLIDE} row_kind_t;

  // One stimulus row, random rows replace the address
  typedef struct packed {
    row_kind_t kind;
    logic      rnd;
    mem_addr_t addr;
    mem_id_t   id;
    mem_len_t  len;
  } stim_row_t;

  localparam int NUM_ROWS = 10;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         icache_req_valid_i;
  icache_line_addr_t icache_line_addr_i;
  logic         dcache_req_valid_i;
  mem_req_t     dcache_req_i;
  logic         mem_req_valid_o;
  mem_req_t     mem_req_o;
  logic         mem_resp_valid_i = 1'b0;
  mem_resp_t    mem_resp_i = '0;
  logic         icache_resp_valid_o;
  icache_line_t icache_line_o;
  logic         dcache_resp_valid_o;
  mem_resp_t    dcache_resp_o;

  stim_row_t    stim_tab [NUM_ROWS];
  int           seed;
  int           cyc = 0;
  int           check_errors = 0;
  int           wait_errors = 0;
  logic         timed_out = 1'b0;

  // Expected traffic, and cycles at which the memory model acted
  mem_req_t     exp_req_q[$];
  int           exp_req_cyc_q[$];
  mem_resp_t    exp_dbeat_q[$];
  icache_line_t exp_line_q[$];
  mem_req_t     mem_q[$];
  int           mem_cyc_q[$];
  int           dbeat_cyc_q[$];
  int           line_cyc_q[$];
  logic         mem_busy = 1'b0;
  mem_req_t     mem_cur = '0;
  mem_len_t     mem_beat = '0;

  always #50 clk_i = ~clk_i;

  cache_mem_bridge i_cache_mem_bridge (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_req_valid_i  (icache_req_valid_i),
    .icache_line_addr_i  (icache_line_addr_i),
    .icache_resp_valid_o (icache_resp_valid_o),
    .icache_line_o       (icache_line_o),
    .dcache_req_valid_i  (dcache_req_valid_i),
    .dcache_req_i        (dcache_req_i),
    .dcache_resp_valid_o (dcache_resp_valid_o),
    .dcache_resp_o       (dcache_resp_o),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_req_o           (mem_req_o),
    .mem_resp_valid_i    (mem_resp_valid_i),
    .mem_resp_i          (mem_resp_i)
  );

  task automatic load_table();
    stim_tab[0] = '{ROW_INSTR,   1'b0, 32'h0000_1000, 2'd0, 2'd0};
    stim_tab[1] = '{ROW_DATA,    1'b0, 32'h0000_2004, 2'd1, 2'd0};
    stim_tab[2] = '{ROW_DATA,    1'b0, 32'h0000_3000, 2'd2, 2'd3};
    stim_tab[3] = '{ROW_COLLIDE, 1'b0, 32'h0000_4000, 2'd3, 2'd1};
    stim_tab[4] = '{ROW_INSTR,   1'b1, 32'h0000_0000, 2'd0, 2'd0};
    stim_tab[5] = '{ROW_DATA,    1'b1, 32'h0000_0000, 2'd1, 2'd2};
    stim_tab[6] = '{ROW_COLLIDE, 1'b1, 32'h0000_0000, 2'd2, 2'd3};
    stim_tab[7] = '{ROW_DATA,    1'b1, 32'h0000_0000, 2'd3, 2'd1};
    stim_tab[8] = '{ROW_INSTR,   1'b1, 32'h0000_0000, 2'd0, 2'd0};
    stim_tab[9] = '{ROW_DATA,    1'b0, 32'h0000_6000, 2'd1, 2'd1};
  endtask

  // Word k of a burst at address A carries A plus 4k
  function automatic icache_line_t line_of(input mem_addr_t addr);
    icache_line_t line;
    for (int k = 0; k < ICACHE_BEATS; k++) begin
      line[k*MEM_DATA_WIDTH +: MEM_DATA_WIDTH] = addr + mem_addr_t'(4 * k);
    end
    return line;
  endfunction

  task automatic expect_dcache(input mem_req_t req);
    mem_resp_t beat;
    for (int k = 0; k <= int'(req.len); k++) begin
      beat.data = req.addr + mem_addr_t'(4 * k);
      beat.id   = req.id;
      beat.last = (k == int'(req.len));
      exp_dbeat_q.push_back(beat);
    end
  endtask

  task automatic push_req(input mem_req_t req, input int at_cyc);
    exp_req_q.push_back(req);
    exp_req_cyc_q.push_back(at_cyc);
  endtask

  task automatic compare_value(input string name, input icache_line_t expected,
                               input icache_line_t actual);
    if (expected !== actual) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  task automatic apply_row(input stim_row_t row);
    mem_addr_t addr;
    mem_req_t  ireq;
    mem_req_t  dreq;
    int        c;
    addr = row.addr;
    if (row.rnd) begin
      addr = mem_addr_t'($random(seed)) & 32'hffff_fffc;
    end
    ireq.addr = {addr[MEM_ADDR_WIDTH-1:4], 4'h0};
    ireq.len  = 2'd3;
    ireq.id   = 2'd0;
    dreq.addr = (row.kind == ROW_COLLIDE) ? (addr ^ 32'h8000_0000) : addr;
    dreq.len  = row.len;
    dreq.id   = row.id;
    @(posedge clk_i);
    #1;
    c = cyc;
    if (row.kind == ROW_DATA) begin
      dcache_req_valid_i = 1'b1;
      dcache_req_i       = dreq;
      push_req(dreq, c + 1);
      expect_dcache(dreq);
    end else begin
      icache_req_valid_i = 1'b1;
      icache_line_addr_i = ireq.addr[MEM_ADDR_WIDTH-1:4];
      exp_line_q.push_back(line_of(ireq.addr));
      if (row.kind == ROW_INSTR) begin
        push_req(ireq, c + 2);
      end else begin
        // Data strobe meets the formatted instruction request at the arbiter
        @(posedge clk_i);
        #1;
        icache_req_valid_i = 1'b0;
        dcache_req_valid_i = 1'b1;
        dcache_req_i       = dreq;
        push_req(dreq, c + 2);
        push_req(ireq, c + 3);
        expect_dcache(dreq);
      end
    end
    @(posedge clk_i);
    #1;
    icache_req_valid_i = 1'b0;
    dcache_req_valid_i = 1'b0;
  endtask

  task automatic wait_for_idle(input int limit);
    int n;
    n = 0;
    while ((exp_req_q.size() + exp_dbeat_q.size() + exp_line_q.size()) != 0 && n < limit) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if ((exp_req_q.size() + exp_dbeat_q.size() + exp_line_q.size()) != 0) begin
      $display("error at %0t: timed out waiting for requests and responses", $time);
      wait_errors++;
      timed_out = 1'b1;
    end
  endtask

  // Monitor and checker, outputs sampled at the clock edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (mem_req_valid_o) begin
        mem_q.push_back(mem_req_o);
        mem_cyc_q.push_back(cyc);
        if (exp_req_q.size() == 0) begin
          $display("error at %0t: memory request issued with none expected", $time);
          check_errors++;
        end else begin
          compare_value("mem_req_o", icache_line_t'(exp_req_q.pop_front()),
                        icache_line_t'(mem_req_o));
          compare_value("mem_req_o cycle", icache_line_t'(exp_req_cyc_q.pop_front()),
                        icache_line_t'(cyc));
        end
      end
      if (dcache_resp_valid_o) begin
        if (exp_dbeat_q.size() == 0 || dbeat_cyc_q.size() == 0) begin
          $display("error at %0t: data cache beat delivered with none expected", $time);
          check_errors++;
        end else begin
          compare_value("dcache_resp_o", icache_line_t'(exp_dbeat_q.pop_front()),
                        icache_line_t'(dcache_resp_o));
          compare_value("dcache_resp_o cycle", icache_line_t'(dbeat_cyc_q.pop_front() + 1),
                        icache_line_t'(cyc));
        end
      end
      if (icache_resp_valid_o) begin
        if (exp_line_q.size() == 0 || line_cyc_q.size() == 0) begin
          $display("error at %0t: instruction line delivered with none expected", $time);
          check_errors++;
        end else begin
          compare_value("icache_line_o", exp_line_q.pop_front(), icache_line_o);
          compare_value("icache_line_o cycle", icache_line_t'(line_cyc_q.pop_front() + 2),
                        icache_line_t'(cyc));
        end
      end
    end
    cyc = cyc + 1;
  end

  // Memory model, one burst at a time, three cycles after the request
  always @(posedge clk_i) begin
    #1;
    mem_resp_valid_i = 1'b0;
    if (!mem_busy && mem_q.size() != 0 && cyc >= mem_cyc_q[0] + 3) begin
      mem_cur  = mem_q.pop_front();
      void'(mem_cyc_q.pop_front());
      mem_busy = 1'b1;
      mem_beat = '0;
    end
    if (mem_busy) begin
      mem_resp_valid_i = 1'b1;
      mem_resp_i.data  = mem_cur.addr + 4 * mem_addr_t'(mem_beat);
      mem_resp_i.id    = mem_cur.id;
      mem_resp_i.last  = (mem_beat == mem_cur.len);
      if (mem_cur.id != 2'd0) begin
        dbeat_cyc_q.push_back(cyc);
      end else if (mem_resp_i.last) begin
        line_cyc_q.push_back(cyc);
      end
      if (mem_resp_i.last) begin
        mem_busy = 1'b0;
      end else begin
        mem_beat = mem_beat + 1'b1;
      end
    end
  end

  initial begin
    rst_ni             = 1'b0;
    icache_req_valid_i = 1'b0;
    icache_line_addr_i = '0;
    dcache_req_valid_i = 1'b0;
    dcache_req_i       = '0;
    seed               = 32'hed78dac8;
    load_table();
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      apply_row(stim_tab[i]);
      wait_for_idle(60);
    end
    // Catch stray strobes after the last row
    repeat (5) @(posedge clk_i);
    $display("errors: %0d check, %0d wait", check_errors, wait_errors);
    if (check_errors == 0 && wait_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
